/* logic/axil_if.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

interface axil_if;

   // write address and data
   logic [`SOC_ADDR_W-1:0]     awaddr;
   logic                       awvalid;
   logic                       awready;
   logic [`SOC_DATA_W-1:0]     wdata;
   logic [`SOC_DATA_W/8-1:0]   wstrb;
   logic                       wvalid;
   logic                       wready;

   // write response
   logic [1:0]                 bresp;
   logic                       bvalid;
   logic                       bready;

   // read address and data
   logic [`SOC_ADDR_W-1:0]     araddr;
   logic                       arvalid;
   logic                       arready;
   logic [`SOC_DATA_W-1:0]     rdata;
   logic [1:0]                 rresp;
   logic                       rvalid;
   logic                       rready;

   modport master (
      output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

   modport slave (
      input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

endinterface

/* logic/cmd_engine.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module cmd_engine (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] rx_data,
   input  logic       rx_valid,
   output logic [7:0] tx_data,
   output logic       tx_valid,
   input  logic       tx_ready,
   axil_if.master     bus,
   output logic       trap
);

   soc_pkg::eng_state_e    state;
   soc_pkg::cmd_op_e       op;
   logic [`SOC_ADDR_W-1:0] addr;
   logic [`SOC_DATA_W-1:0] wdata;
   logic [1:0]             byte_cnt;
   logic [`SOC_DATA_W-1:0] queue;
   logic [2:0]             q_cnt;
   logic                   aw_done;
   logic                   w_done;

   assign bus.awaddr = addr;
   assign bus.araddr = addr;
   assign bus.wdata  = wdata;
   assign bus.wstrb  = '1;
   assign bus.bready = (state == soc_pkg::AXI_RESP);
   assign bus.rready = (state == soc_pkg::AXI_RDATA);

   // reply queue drains from its low byte
   assign tx_data  = queue[7:0];
   assign tx_valid = (state == soc_pkg::SEND);

   // channel handshake done, in this cycle or an earlier one
   assign aw_done = !bus.awvalid || bus.awready;
   assign w_done  = !bus.wvalid || bus.wready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= soc_pkg::GET_OP;
         op          <= soc_pkg::OP_READ;
         byte_cnt    <= '0;
         q_cnt       <= '0;
         trap        <= 1'b0;
         bus.awvalid <= 1'b0;
         bus.wvalid  <= 1'b0;
         bus.arvalid <= 1'b0;
      end else begin
         case (state)
            soc_pkg::GET_OP: begin
               if (rx_valid) begin
                  if (rx_data == soc_pkg::OP_WRITE || rx_data == soc_pkg::OP_READ) begin
                     op    <= soc_pkg::cmd_op_e'(rx_data);
                     state <= soc_pkg::GET_ADDR;
                  end else begin
                     // unknown opcode, trap stays set until reset
                     queue <= {{(`SOC_DATA_W-8){1'b0}}, soc_pkg::RSP_BAD};
                     q_cnt <= 3'd1;
                     trap  <= 1'b1;
                     state <= soc_pkg::SEND;
                  end
               end
            end
            soc_pkg::GET_ADDR: begin
               if (rx_valid) begin
                  addr <= rx_data;
                  if (op == soc_pkg::OP_WRITE) begin
                     byte_cnt <= '0;
                     state    <= soc_pkg::GET_DATA;
                  end else begin
                     bus.arvalid <= 1'b1;
                     state       <= soc_pkg::AXI_READ;
                  end
               end
            end
            soc_pkg::GET_DATA: begin
               if (rx_valid) begin
                  // lsb first, so shift in from the top
                  wdata    <= {rx_data, wdata[`SOC_DATA_W-1:8]};
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == 2'd3) begin
                     bus.awvalid <= 1'b1;
                     bus.wvalid  <= 1'b1;
                     state       <= soc_pkg::AXI_WRITE;
                  end
               end
            end
            soc_pkg::AXI_WRITE: begin
               if (bus.awready) begin
                  bus.awvalid <= 1'b0;
               end
               if (bus.wready) begin
                  bus.wvalid <= 1'b0;
               end
               if (aw_done && w_done) begin
                  state <= soc_pkg::AXI_RESP;
               end
            end
            soc_pkg::AXI_RESP: begin
               if (bus.bvalid) begin
                  queue <= {{(`SOC_DATA_W-8){1'b0}},
                            (bus.bresp == soc_pkg::RESP_OKAY) ? soc_pkg::RSP_OK
                                                               : soc_pkg::RSP_ERR};
                  q_cnt <= 3'd1;
                  state <= soc_pkg::SEND;
               end
            end
            soc_pkg::AXI_READ: begin
               if (bus.arready) begin
                  bus.arvalid <= 1'b0;
                  state       <= soc_pkg::AXI_RDATA;
               end
            end
            soc_pkg::AXI_RDATA: begin
               if (bus.rvalid) begin
                  if (bus.rresp == soc_pkg::RESP_OKAY) begin
                     queue <= bus.rdata;
                     q_cnt <= 3'd4;
                  end else begin
                     queue <= {{(`SOC_DATA_W-8){1'b0}}, soc_pkg::RSP_ERR};
                     q_cnt <= 3'd1;
                  end
                  state <= soc_pkg::SEND;
               end
            end
            soc_pkg::SEND: begin
               // wait here while the transmitter is busy
               if (tx_ready) begin
                  queue <= queue >> 8;
                  q_cnt <= q_cnt - 1'b1;
                  if (q_cnt == 3'd1) begin
                     state <= soc_pkg::GET_OP;
                  end
               end
            end
            default: state <= soc_pkg::GET_OP;
         endcase
      end
   end

   // write address must stay up, unchanged, until the slave takes it
   assert property (@(posedge clk) disable iff (!rst_n)
      bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr));

endmodule

/* logic/mem_axil.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module mem_axil (
   input  logic   clk,
   input  logic   rst_n,
   axil_if.slave  bus
);

   localparam int IDX_W = $clog2(`SOC_MEM_DEPTH);

   logic [`SOC_DATA_W-1:0] mem [`SOC_MEM_DEPTH];
   logic                   wr_rdy;
   logic                   rd_rdy;
   logic                   aw_in_range;
   logic                   ar_in_range;

   // address and data channels are accepted together
   assign bus.awready = wr_rdy;
   assign bus.wready  = wr_rdy;
   assign bus.arready = rd_rdy;

   assign aw_in_range = (bus.awaddr < `SOC_MEM_DEPTH);
   assign ar_in_range = (bus.araddr < `SOC_MEM_DEPTH);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_rdy     <= 1'b0;
         rd_rdy     <= 1'b0;
         bus.bvalid <= 1'b0;
         bus.rvalid <= 1'b0;
      end else begin
         // one pulse per transaction, none while a response is pending
         wr_rdy <= bus.awvalid && bus.wvalid && !wr_rdy && !bus.bvalid;
         rd_rdy <= bus.arvalid && !rd_rdy && !bus.rvalid;
         if (wr_rdy) begin
            bus.bvalid <= 1'b1;
         end else if (bus.bready) begin
            bus.bvalid <= 1'b0;
         end
         if (rd_rdy) begin
            bus.rvalid <= 1'b1;
         end else if (bus.rready) begin
            bus.rvalid <= 1'b0;
         end
      end
   end

   // out of range writes leave memory alone
   always_ff @(posedge clk) begin
      if (wr_rdy) begin
         bus.bresp <= aw_in_range ? soc_pkg::RESP_OKAY : soc_pkg::RESP_SLVERR;
         if (aw_in_range) begin
            for (int b = 0; b < `SOC_DATA_W/8; b++) begin
               if (bus.wstrb[b]) begin
                  mem[bus.awaddr[IDX_W-1:0]][8*b +: 8] <= bus.wdata[8*b +: 8];
               end
            end
         end
      end
      if (rd_rdy) begin
         bus.rresp <= ar_in_range ? soc_pkg::RESP_OKAY : soc_pkg::RESP_SLVERR;
         bus.rdata <= ar_in_range ? mem[bus.araddr[IDX_W-1:0]] : '0;
      end
   end

   // responses wait for the master
   assert property (@(posedge clk) disable iff (!rst_n)
      bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp));

   assert property (@(posedge clk) disable iff (!rst_n)
      bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata));

endmodule

/* logic/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// clk cycles per uart bit
`define SOC_BAUD_DIV 8

// words in the stand-in for external memory
`define SOC_MEM_DEPTH 64

// axi-lite address width, the address is the frame's byte index
`define SOC_ADDR_W 8

// axi-lite data width
`define SOC_DATA_W 32

`endif

/* logic/soc_pkg.sv */
package soc_pkg;

   // opcodes sent by the host as the first frame byte
   typedef enum logic [7:0] {
      OP_WRITE = 8'h57,
      OP_READ  = 8'h52
   } cmd_op_e;

   // command engine states
   typedef enum logic [2:0] {
      GET_OP,
      GET_ADDR,
      GET_DATA,
      AXI_WRITE,
      AXI_RESP,
      AXI_READ,
      AXI_RDATA,
      SEND
   } eng_state_e;

   // reply bytes
   localparam logic [7:0] RSP_OK  = 8'h4B;
   localparam logic [7:0] RSP_ERR = 8'h45;
   localparam logic [7:0] RSP_BAD = 8'h3F;

   // axi response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* logic/top_system.sv */
`timescale 1ns/1ps

module top_system (
   input  logic clk,
   input  logic rst_n,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic trap
);

   logic [7:0] rx_data;
   logic       rx_valid;
   logic [7:0] tx_data;
   logic       tx_valid;
   logic       tx_ready;

   // engine to memory
   axil_if axil ();

   uart_rx uart_rx_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .uart_rxd (uart_rxd),
      .rx_data  (rx_data),
      .rx_valid (rx_valid)
   );

   cmd_engine cmd_engine_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rx_data  (rx_data),
      .rx_valid (rx_valid),
      .tx_data  (tx_data),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .bus      (axil.master),
      .trap     (trap)
   );

   // stands in for the ddr controller
   mem_axil mem_axil_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (axil.slave)
   );

   uart_tx uart_tx_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .tx_data  (tx_data),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .uart_txd (uart_txd)
   );

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module uart_rx (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       uart_rxd,
   output logic [7:0] rx_data,
   output logic       rx_valid
);

   localparam int CNT_W = $clog2(`SOC_BAUD_DIV);
   localparam int HALF  = `SOC_BAUD_DIV / 2;

   logic [1:0]       rxd_sync;
   logic             busy;
   logic [3:0]       bit_idx;
   logic [CNT_W-1:0] baud_cnt;

   // two flops on the async line, idle high
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rxd_sync <= 2'b11;
      end else begin
         rxd_sync <= {rxd_sync[0], uart_rxd};
      end
   end

   // bit_idx 0 is start, 1 to 8 data, 9 stop
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         bit_idx  <= '0;
         baud_cnt <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (!busy) begin
            if (!rxd_sync[1]) begin
               // half a bit puts the sample point mid start bit
               busy     <= 1'b1;
               bit_idx  <= '0;
               baud_cnt <= CNT_W'(HALF - 1);
            end
         end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
         end else begin
            baud_cnt <= CNT_W'(`SOC_BAUD_DIV - 1);
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 4'd0 && rxd_sync[1]) begin
               busy <= 1'b0;  // start glitch, back to idle
            end else if (bit_idx == 4'd9) begin
               busy     <= 1'b0;
               // framing error if stop bit is low
               rx_valid <= rxd_sync[1];
            end
         end
      end
   end

   // data bits come lsb first
   always_ff @(posedge clk) begin
      if (busy && baud_cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
         rx_data <= {rxd_sync[1], rx_data[7:1]};
      end
   end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module uart_tx (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] tx_data,
   input  logic       tx_valid,
   output logic       tx_ready,
   output logic       uart_txd
);

   localparam int CNT_W = $clog2(`SOC_BAUD_DIV);

   logic             busy;
   logic [8:0]       shift;
   logic [3:0]       bits_left;
   logic [CNT_W-1:0] baud_cnt;

   assign tx_ready = !busy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         bits_left <= '0;
         baud_cnt  <= '0;
         uart_txd  <= 1'b1;
      end else if (!busy) begin
         if (tx_valid) begin
            // start bit goes out on the next edge
            busy      <= 1'b1;
            uart_txd  <= 1'b0;
            bits_left <= 4'd9;
            baud_cnt  <= CNT_W'(`SOC_BAUD_DIV - 1);
         end
      end else if (baud_cnt != '0) begin
         baud_cnt <= baud_cnt - 1'b1;
      end else if (bits_left == '0) begin
         busy <= 1'b0;  // stop bit finished
      end else begin
         uart_txd  <= shift[0];
         bits_left <= bits_left - 1'b1;
         baud_cnt  <= CNT_W'(`SOC_BAUD_DIV - 1);
      end
   end

   // eight data bits lsb first, then the stop bit
   always_ff @(posedge clk) begin
      if (!busy && tx_valid) begin
         shift <= {1'b1, tx_data};
      end else if (busy && baud_cnt == '0 && bits_left != '0) begin
         shift <= {1'b1, shift[8:1]};
      end
   end

   // sender must hold the byte while the line is busy
   assert property (@(posedge clk) disable iff (!rst_n)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

/* verification/tb_top_system.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_top_system;

   // reply and opcode bytes as the host sees them
   localparam logic [7:0] CMD_WRITE = 8'h57;
   localparam logic [7:0] CMD_READ  = 8'h52;
   localparam logic [7:0] RSP_OK    = 8'h4B;
   localparam logic [7:0] RSP_ERR   = 8'h45;
   localparam logic [7:0] RSP_BAD   = 8'h3F;
   localparam int REPLY_WAIT = 200;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        uart_rxd;
   logic        uart_txd;
   logic        trap;
   int          errors = 0;
   int          tests = 0;
   logic [31:0] lfsr_state = 32'h81128cc5;
   logic [31:0] model_mem [`SOC_MEM_DEPTH];
   logic [7:0]  wr_addrs [$];

   top_system top_system_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .trap     (trap)
   );

   always #50 clk = ~clk;

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic send_bit(input logic b);
      @(posedge clk);
      #1 uart_rxd = b;
      repeat (`SOC_BAUD_DIV - 1) @(posedge clk);
   endtask

   // 8N1, lsb first
   task automatic send_byte(input logic [7:0] b);
      send_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         send_bit(b[i]);
      end
      send_bit(1'b1);
   endtask

   // samples on the falling edge, mid bit
   task automatic recv_byte(input int limit, output logic [7:0] b, output bit got);
      int n;
      got = 1'b0;
      b = '0;
      n = 0;
      @(negedge clk);
      while (uart_txd !== 1'b0 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (uart_txd === 1'b0) begin
         got = 1'b1;
         repeat (`SOC_BAUD_DIV / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            repeat (`SOC_BAUD_DIV) @(negedge clk);
            b[i] = uart_txd;
         end
         repeat (`SOC_BAUD_DIV) @(negedge clk);
         if (uart_txd !== 1'b1) begin
            $display("stop bit on uart_txd was low");
            errors++;
         end
      end
   endtask

   task automatic expect_byte(input logic [7:0] exp, input string name);
      logic [7:0] b;
      bit         got;
      recv_byte(REPLY_WAIT, b, got);
      if (!got) begin
         $display("timed out waiting for a reply byte on uart_txd (%s)", name);
         errors++;
      end else if (b !== exp) begin
         $display("ERROR %s expected %h got %h", name, exp, b);
         errors++;
      end
   endtask

   task automatic do_write(input logic [7:0] a, input logic [31:0] d);
      send_byte(CMD_WRITE);
      send_byte(a);
      for (int i = 0; i < 4; i++) begin
         send_byte(d[8*i +: 8]);
      end
      if (a < `SOC_MEM_DEPTH) begin
         model_mem[a] = d;
         expect_byte(RSP_OK, "uart_txd write reply");
      end else begin
         expect_byte(RSP_ERR, "uart_txd write reply");
      end
   endtask

   task automatic do_read(input logic [7:0] a);
      send_byte(CMD_READ);
      send_byte(a);
      if (a < `SOC_MEM_DEPTH) begin
         for (int i = 0; i < 4; i++) begin
            expect_byte(model_mem[a][8*i +: 8], "uart_txd read byte");
         end
      end else begin
         expect_byte(RSP_ERR, "uart_txd read reply");
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "pass" : "fail");
   endtask

   initial begin
      logic [7:0]  a;
      logic [7:0]  b;
      bit          got;
      int          e;
      rst_n = 1'b0;
      uart_rxd = 1'b1;
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;

      e = errors;
      @(negedge clk);
      if (uart_txd !== 1'b1) begin
         $display("ERROR uart_txd expected %h got %h", 1'b1, uart_txd);
         errors++;
      end
      if (trap !== 1'b0) begin
         $display("ERROR trap expected %h got %h", 1'b0, trap);
         errors++;
      end
      recv_byte(300, b, got);
      if (got) begin
         $display("a reply byte appeared on uart_txd with no command sent");
         errors++;
      end
      end_test("idle after reset", e);

      e = errors;
      for (int i = 0; i < 8; i++) begin
         a = rand_bits(6);
         wr_addrs.push_back(a);
         do_write(a, rand_bits(32));
      end
      foreach (wr_addrs[i]) begin
         do_read(wr_addrs[i]);
      end
      end_test("random write and read-back", e);

      e = errors;
      do_write(wr_addrs[0], rand_bits(32));
      do_write(wr_addrs[0], rand_bits(32));
      do_read(wr_addrs[0]);
      end_test("overwrite", e);

      // low bits of the bad address point at a known word
      e = errors;
      a = rand_bits(8);
      if (a < `SOC_MEM_DEPTH) begin
         a = a + 8'd64;
      end
      do_write(a % `SOC_MEM_DEPTH, rand_bits(32));
      do_write(a, rand_bits(32));
      do_read(a);
      do_read(a % `SOC_MEM_DEPTH);
      end_test("out of range access", e);

      e = errors;
      b = rand_bits(8);
      while (b == CMD_WRITE || b == CMD_READ) begin
         b = rand_bits(8);
      end
      // valid commands so far must not have set trap
      if (trap !== 1'b0) begin
         $display("ERROR trap expected %h got %h", 1'b0, trap);
         errors++;
      end
      send_byte(b);
      expect_byte(RSP_BAD, "uart_txd bad opcode reply");
      do_write(wr_addrs[1], rand_bits(32));
      do_read(wr_addrs[1]);
      if (trap !== 1'b1) begin
         $display("ERROR trap expected %h got %h", 1'b1, trap);
         errors++;
      end
      end_test("bad opcode and trap", e);

      e = errors;
      for (int i = 0; i < 12; i++) begin
         do_read(wr_addrs[rand_bits(3)]);
      end
      end_test("back-to-back reads", e);

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+logic
logic/soc_pkg.sv
logic/axil_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cmd_engine.sv
logic/mem_axil.sv
logic/top_system.sv
verification/tb_top_system.sv
